/* hw/cpu_cfg.svh */
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// datapath widths
`define CPU_WORD_W      32
`define CPU_REG_IDX_W   5
`define CPU_PC_W        6
`define CPU_DADDR_W     6
`define CPU_ALU_OP_W    3
`define CPU_FWD_W       2

// memory depths in words
`define CPU_IMEM_DEPTH  64
`define CPU_DMEM_DEPTH  64

// byte address of the output port
`define CPU_OUT_ADDR    32'h0000_0100

// opcodes
`define CPU_OP_RTYPE    6'h00
`define CPU_OP_ADDI     6'h08
`define CPU_OP_LW       6'h23
`define CPU_OP_SW       6'h2b
`define CPU_OP_BEQ      6'h04

// funct codes for r-type
`define CPU_FN_ADD      6'h20
`define CPU_FN_SUB      6'h22
`define CPU_FN_AND      6'h24
`define CPU_FN_OR       6'h25
`define CPU_FN_SLT      6'h2a

`define ALU_ADD         3'd0
`define ALU_SUB         3'd1
`define ALU_AND         3'd2
`define ALU_OR          3'd3
`define ALU_SLT         3'd4

// forwarding source for an EX operand
`define FWD_NONE        2'd0
`define FWD_MEM         2'd1
`define FWD_WB          2'd2

`endif

/* hw/cpu_pkg.sv */
`default_nettype none
`include "cpu_cfg.svh"

package cpu_pkg;

    typedef logic [`CPU_WORD_W-1:0]    word_t;
    typedef logic [`CPU_REG_IDX_W-1:0] reg_idx_t;

    // word addresses, not byte addresses
    typedef logic [`CPU_PC_W-1:0]      pc_t;
    typedef logic [`CPU_DADDR_W-1:0]   daddr_t;

    typedef logic [`CPU_ALU_OP_W-1:0]  alu_op_t;
    typedef logic [`CPU_FWD_W-1:0]     fwd_sel_t;

endpackage

`default_nettype wire

/* hw/fetch_stage.sv */
`default_nettype none
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module fetch_stage import cpu_pkg::*; (
    input  wire        clk,
    input  wire        arst_n,
    input  wire        start,
    input  wire        prog_we,
    input  wire pc_t   prog_addr,
    input  wire word_t prog_data,
    input  wire        stall,
    input  wire        branch_taken,
    input  wire pc_t   branch_target,
    output word_t      id_instr,
    output pc_t        id_pc,
    output logic       id_valid
);

    word_t imem [`CPU_IMEM_DEPTH];
    pc_t   pc;
    logic  running;

    // program load only while idle
    always_ff @(posedge clk) begin
        if (prog_we && !running) begin
            imem[prog_addr] <= prog_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            running  <= 1'b0;
            pc       <= '0;
            id_valid <= 1'b0;
        end else if (start) begin
            running  <= 1'b1;
            pc       <= '0;
            id_valid <= 1'b0;
        end else if (running) begin
            if (branch_taken) begin
                // squash the instruction fetched behind the branch
                pc       <= branch_target;
                id_valid <= 1'b0;
            end else if (!stall) begin
                pc       <= pc + pc_t'(1);
                id_valid <= 1'b1;
            end
        end
    end

    // IF/ID payload
    always_ff @(posedge clk) begin
        if (running && !stall && !branch_taken) begin
            id_instr <= imem[pc];
            id_pc    <= pc;
        end
    end

endmodule

`default_nettype wire

/* hw/hazard_unit.sv */
`default_nettype none
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module hazard_unit import cpu_pkg::*; (
    input  wire word_t    id_instr,
    input  wire           id_valid,
    input  wire           ex_valid,
    input  wire           ex_mem_read,
    input  wire           ex_reg_write,
    input  wire reg_idx_t ex_dest,
    input  wire           mem_valid,
    input  wire           mem_reg_write,
    input  wire reg_idx_t mem_dest,
    output logic          stall
);

    logic [5:0] opcode;
    reg_idx_t   rs;
    reg_idx_t   rt;
    logic       is_beq;
    logic       uses_rs;
    logic       uses_rt;
    logic       ex_pending;
    logic       mem_pending;
    logic       load_use;
    logic       branch_dep;

    assign opcode  = id_instr[31:26];
    assign rs      = id_instr[25:21];
    assign rt      = id_instr[20:16];
    assign is_beq  = opcode == `CPU_OP_BEQ;
    assign uses_rt = opcode inside {`CPU_OP_RTYPE, `CPU_OP_SW, `CPU_OP_BEQ};
    assign uses_rs = uses_rt || opcode inside {`CPU_OP_ADDI, `CPU_OP_LW};

    // writes to r0 never block
    assign ex_pending  = ex_valid && ex_reg_write && ex_dest != '0;
    assign mem_pending = mem_valid && mem_reg_write && mem_dest != '0;

    assign load_use = ex_pending && ex_mem_read &&
                      ((uses_rs && rs == ex_dest) || (uses_rt && rt == ex_dest));

    // beq compares in ID, so it waits until the producer is in WB
    assign branch_dep = is_beq &&
                        ((ex_pending && (rs == ex_dest || rt == ex_dest)) ||
                         (mem_pending && (rs == mem_dest || rt == mem_dest)));

    assign stall = id_valid && (load_use || branch_dep);

endmodule

`default_nettype wire

/* hw/decode_stage.sv */
`default_nettype none
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module decode_stage import cpu_pkg::*; (
    input  wire           clk,
    input  wire           arst_n,
    input  wire word_t    id_instr,
    input  wire pc_t      id_pc,
    input  wire           id_valid,
    input  wire           stall,
    input  wire           wb_we,
    input  wire reg_idx_t wb_idx,
    input  wire word_t    wb_data,
    output logic          branch_taken,
    output pc_t           branch_target,
    output logic          ex_valid,
    output alu_op_t       ex_alu_op,
    output word_t         ex_op_a,
    output word_t         ex_op_b,
    output word_t         ex_store_data,
    output reg_idx_t      ex_src_a,
    output reg_idx_t      ex_src_b,
    output reg_idx_t      ex_dest,
    output logic          ex_reg_write,
    output logic          ex_mem_read,
    output logic          ex_mem_write
);

    word_t      rf [1 << `CPU_REG_IDX_W];
    logic [5:0] opcode;
    logic [5:0] funct;
    reg_idx_t   rs;
    reg_idx_t   rt;
    reg_idx_t   rd;
    word_t      imm_ext;
    word_t      rd_a;
    word_t      rd_b;
    logic       is_rtype;
    logic       is_addi;
    logic       is_lw;
    logic       is_sw;
    logic       is_beq;
    logic       use_imm;
    logic       fn_ok;
    logic       load_ok;
    alu_op_t    alu_op;

    assign opcode   = id_instr[31:26];
    assign rs       = id_instr[25:21];
    assign rt       = id_instr[20:16];
    assign rd       = id_instr[15:11];
    assign funct    = id_instr[5:0];
    assign imm_ext  = {{16{id_instr[15]}}, id_instr[15:0]};
    assign is_rtype = opcode == `CPU_OP_RTYPE;
    assign is_addi  = opcode == `CPU_OP_ADDI;
    assign is_lw    = opcode == `CPU_OP_LW;
    assign is_sw    = opcode == `CPU_OP_SW;
    assign is_beq   = opcode == `CPU_OP_BEQ;
    assign use_imm  = is_addi || is_lw || is_sw;

    always_comb begin
        fn_ok  = 1'b1;
        alu_op = `ALU_ADD;
        if (is_rtype) begin
            case (funct)
                `CPU_FN_ADD: alu_op = `ALU_ADD;
                `CPU_FN_SUB: alu_op = `ALU_SUB;
                `CPU_FN_AND: alu_op = `ALU_AND;
                `CPU_FN_OR:  alu_op = `ALU_OR;
                `CPU_FN_SLT: alu_op = `ALU_SLT;
                default:     fn_ok  = 1'b0;
            endcase
        end
    end

    // register file, WB write is visible to the read in the same cycle
    always_ff @(posedge clk) begin
        if (wb_we && wb_idx != '0) begin
            rf[wb_idx] <= wb_data;
        end
    end

    assign rd_a = (rs == '0) ? '0 : (wb_we && wb_idx == rs) ? wb_data : rf[rs];
    assign rd_b = (rt == '0) ? '0 : (wb_we && wb_idx == rt) ? wb_data : rf[rt];

    assign branch_taken  = id_valid && !stall && is_beq && rd_a == rd_b;
    assign branch_target = id_pc + pc_t'(1) + imm_ext[`CPU_PC_W-1:0];

    // unknown opcodes leave as bubbles
    assign load_ok = id_valid && !stall &&
                     ((is_rtype && fn_ok) || use_imm || is_beq);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid     <= 1'b0;
            ex_reg_write <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
        end else begin
            ex_valid     <= load_ok;
            ex_reg_write <= load_ok && (is_rtype || is_addi || is_lw);
            ex_mem_read  <= load_ok && is_lw;
            ex_mem_write <= load_ok && is_sw;
        end
    end

    always_ff @(posedge clk) begin
        ex_alu_op     <= alu_op;
        ex_op_a       <= rd_a;
        ex_op_b       <= use_imm ? imm_ext : rd_b;
        ex_store_data <= rd_b;
        ex_src_a      <= rs;
        // rt is only a source for r-type and the sw data
        ex_src_b      <= (is_rtype || is_sw) ? rt : '0;
        ex_dest       <= is_rtype ? rd : (is_addi || is_lw) ? rt : '0;
    end

endmodule

`default_nettype wire

/* hw/execute_stage.sv */
`default_nettype none
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module execute_stage import cpu_pkg::*; (
    input  wire           clk,
    input  wire           arst_n,
    input  wire           ex_valid,
    input  wire alu_op_t  ex_alu_op,
    input  wire word_t    ex_op_a,
    input  wire word_t    ex_op_b,
    input  wire word_t    ex_store_data,
    input  wire reg_idx_t ex_src_a,
    input  wire reg_idx_t ex_src_b,
    input  wire reg_idx_t ex_dest,
    input  wire           ex_reg_write,
    input  wire           ex_mem_read,
    input  wire           ex_mem_write,
    input  wire           wb_we,
    input  wire reg_idx_t wb_idx,
    input  wire word_t    wb_data,
    output logic          mem_valid,
    output word_t         mem_alu_result,
    output word_t         mem_store_data,
    output reg_idx_t      mem_dest,
    output logic          mem_reg_write,
    output logic          mem_mem_read,
    output logic          mem_mem_write
);

    fwd_sel_t sel_a;
    fwd_sel_t sel_b;
    fwd_sel_t sel_st;
    logic     mem_fwd_en;
    word_t    op_a;
    word_t    op_b;
    word_t    st_data;
    word_t    alu_res;

    // MEM wins over WB, r0 is never forwarded
    function automatic fwd_sel_t fwd_for(input reg_idx_t src, input logic mem_en,
                                         input reg_idx_t mdest, input logic wb_en,
                                         input reg_idx_t wdest);
        if (src == '0)
            return `FWD_NONE;
        if (mem_en && mdest == src)
            return `FWD_MEM;
        if (wb_en && wdest == src)
            return `FWD_WB;
        return `FWD_NONE;
    endfunction

    function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t base,
                                      input word_t mem_val, input word_t wb_val);
        case (sel)
            `FWD_MEM: return mem_val;
            `FWD_WB:  return wb_val;
            default:  return base;
        endcase
    endfunction

    assign mem_fwd_en = mem_valid && mem_reg_write;
    assign sel_a      = fwd_for(ex_src_a, mem_fwd_en, mem_dest, wb_we, wb_idx);
    assign sel_st     = fwd_for(ex_src_b, mem_fwd_en, mem_dest, wb_we, wb_idx);
    // sw carries its offset in operand b
    assign sel_b      = ex_mem_write ? `FWD_NONE : sel_st;

    assign op_a    = fwd_mux(sel_a, ex_op_a, mem_alu_result, wb_data);
    assign op_b    = fwd_mux(sel_b, ex_op_b, mem_alu_result, wb_data);
    assign st_data = fwd_mux(sel_st, ex_store_data, mem_alu_result, wb_data);

    always_comb begin
        case (ex_alu_op)
            `ALU_SUB: alu_res = op_a - op_b;
            `ALU_AND: alu_res = op_a & op_b;
            `ALU_OR:  alu_res = op_a | op_b;
            `ALU_SLT: alu_res = word_t'($signed(op_a) < $signed(op_b));
            default:  alu_res = op_a + op_b;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_valid     <= 1'b0;
            mem_reg_write <= 1'b0;
            mem_mem_read  <= 1'b0;
            mem_mem_write <= 1'b0;
        end else begin
            mem_valid     <= ex_valid;
            mem_reg_write <= ex_valid && ex_reg_write;
            mem_mem_read  <= ex_valid && ex_mem_read;
            mem_mem_write <= ex_valid && ex_mem_write;
        end
    end

    always_ff @(posedge clk) begin
        mem_alu_result <= alu_res;
        mem_store_data <= st_data;
        mem_dest       <= ex_dest;
    end

endmodule

`default_nettype wire

/* hw/memory_stage.sv */
`default_nettype none
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module memory_stage import cpu_pkg::*; (
    input  wire           clk,
    input  wire           arst_n,
    input  wire           mem_valid,
    input  wire word_t    mem_alu_result,
    input  wire word_t    mem_store_data,
    input  wire reg_idx_t mem_dest,
    input  wire           mem_reg_write,
    input  wire           mem_mem_read,
    input  wire           mem_mem_write,
    output logic          wb_we,
    output reg_idx_t      wb_idx,
    output word_t         wb_data,
    output logic          out_valid,
    output word_t         out_data
);

    word_t  dmem [`CPU_DMEM_DEPTH];
    daddr_t daddr;
    logic   to_out;
    logic   st_en;
    logic   wb_is_load;
    word_t  wb_alu;
    word_t  wb_load;

    // byte address to word address
    assign daddr  = mem_alu_result[`CPU_DADDR_W+1:2];
    // full compare, so no data word aliases the output port
    assign to_out = mem_alu_result == `CPU_OUT_ADDR;
    assign st_en  = mem_valid && mem_mem_write;

    always_ff @(posedge clk) begin
        if (st_en && !to_out) begin
            dmem[daddr] <= mem_store_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_we     <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            wb_we     <= mem_valid && mem_reg_write && mem_dest != '0;
            out_valid <= st_en && to_out;
        end
    end

    // MEM/WB
    always_ff @(posedge clk) begin
        wb_idx     <= mem_dest;
        wb_is_load <= mem_mem_read;
        wb_alu     <= mem_alu_result;
        wb_load    <= dmem[daddr];
        out_data   <= mem_store_data;
    end

    assign wb_data = wb_is_load ? wb_load : wb_alu;

endmodule

`default_nettype wire

/* hw/cpu_top.sv */
`default_nettype none
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; (
    input  wire        clk,
    input  wire        arst_n,
    input  wire        prog_we,
    input  wire pc_t   prog_addr,
    input  wire word_t prog_data,
    input  wire        start,
    output wire        out_valid,
    output wire word_t out_data
);

    // IF/ID and branch redirect
    wire word_t    id_instr;
    wire pc_t      id_pc;
    wire           id_valid;
    wire           stall;
    wire           branch_taken;
    wire pc_t      branch_target;

    // ID/EX
    wire           ex_valid;
    wire alu_op_t  ex_alu_op;
    wire word_t    ex_op_a;
    wire word_t    ex_op_b;
    wire word_t    ex_store_data;
    wire reg_idx_t ex_src_a;
    wire reg_idx_t ex_src_b;
    wire reg_idx_t ex_dest;
    wire           ex_reg_write;
    wire           ex_mem_read;
    wire           ex_mem_write;

    // EX/MEM
    wire           mem_valid;
    wire word_t    mem_alu_result;
    wire word_t    mem_store_data;
    wire reg_idx_t mem_dest;
    wire           mem_reg_write;
    wire           mem_mem_read;
    wire           mem_mem_write;

    // write-back, also the WB forwarding source
    wire           wb_we;
    wire reg_idx_t wb_idx;
    wire word_t    wb_data;

    fetch_stage   u_fetch_stage   (.*);
    hazard_unit   u_hazard_unit   (.*);
    decode_stage  u_decode_stage  (.*);
    execute_stage u_execute_stage (.*);
    memory_stage  u_memory_stage  (.*);

endmodule

`default_nettype wire

/* testbench/tb_cpu.sv */
`default_nettype none
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module tb_cpu import cpu_pkg::*; ();

    // six runs of at most about 400 cycles each, plus reset and load
    localparam int TIMEOUT_CYCLES = 2500;
    localparam int RUN_LIMIT      = 400;
    localparam int QUIET_CYCLES   = 20;

    logic  clk = 1'b0;
    logic  arst_n;
    logic  prog_we;
    pc_t   prog_addr;
    word_t prog_data;
    logic  start;
    logic  out_valid;
    word_t out_data;

    word_t  prog_q[$];
    word_t  exp_q[$];
    word_t  got_q[$];
    word_t  model_rf [32];
    word_t  model_dmem [`CPU_DMEM_DEPTH];
    integer seed = 48385;
    int     cycle_count = 0;

    cpu_top u_cpu_top (
        .clk       (clk),
        .arst_n    (arst_n),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .start     (start),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    always #20 clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            fail_run($sformatf("timeout: the run did not finish within %0d cycles",
                               TIMEOUT_CYCLES));
        end
    end

    task automatic compare_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Error: t=%0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic compare_count(input string name, input int got, input int exp);
        if (got != exp) begin
            fail_run($sformatf("Error: t=%0t %s got %0d expected %0d", $time, name, got, exp));
        end
    endtask

    // instruction encoders
    function automatic word_t r_instr(input logic [5:0] fn, input int rd, input int rs,
                                      input int rt);
        return {`CPU_OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
    endfunction

    function automatic word_t i_instr(input logic [5:0] op, input int rt, input int rs,
                                      input int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    task automatic put_instr(input word_t w);
        prog_q.push_back(w);
    endtask

    task automatic store_to_output(input int rt);
        put_instr(i_instr(`CPU_OP_SW, rt, 0, `CPU_OUT_ADDR));
    endtask

    // beq r0, r0, -1 spins in place
    task automatic end_program();
        put_instr(i_instr(`CPU_OP_BEQ, 0, 0, -1));
    endtask

    // ISA-level model, one instruction per step, state kept between runs
    task automatic run_model();
        word_t    ins;
        word_t    a;
        word_t    b;
        word_t    imm;
        word_t    res;
        word_t    addr;
        pc_t      pc;
        pc_t      target;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        exp_q.delete();
        pc = '0;
        for (int step = 0; step < 1000; step++) begin
            ins  = prog_q[pc];
            rs   = ins[25:21];
            rt   = ins[20:16];
            rd   = ins[15:11];
            imm  = {{16{ins[15]}}, ins[15:0]};
            a    = (rs == '0) ? '0 : model_rf[rs];
            b    = (rt == '0) ? '0 : model_rf[rt];
            addr = a + imm;
            target = pc + pc_t'(1);
            case (ins[31:26])
                `CPU_OP_RTYPE: begin
                    case (ins[5:0])
                        `CPU_FN_SUB: res = a - b;
                        `CPU_FN_AND: res = a & b;
                        `CPU_FN_OR:  res = a | b;
                        `CPU_FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:     res = a + b;
                    endcase
                    if (rd != '0) model_rf[rd] = res;
                end
                `CPU_OP_ADDI: if (rt != '0) model_rf[rt] = addr;
                `CPU_OP_LW:   if (rt != '0) model_rf[rt] = model_dmem[addr[7:2]];
                `CPU_OP_SW: begin
                    if (addr == `CPU_OUT_ADDR) exp_q.push_back(b);
                    else model_dmem[addr[7:2]] = b;
                end
                `CPU_OP_BEQ: if (a == b) target = pc + pc_t'(1) + imm[5:0];
                default: ;
            endcase
            if (target == pc) break;
            pc = target;
        end
    endtask

    task automatic reset_dut();
        @(negedge clk);
        arst_n = 1'b0;
        repeat (2) @(negedge clk);
        arst_n = 1'b1;
    endtask

    task automatic load_program();
        for (int i = 0; i < prog_q.size(); i++) begin
            @(negedge clk);
            prog_we   = 1'b1;
            prog_addr = pc_t'(i);
            prog_data = prog_q[i];
        end
        @(negedge clk);
        prog_we = 1'b0;
    endtask

    task automatic run_and_collect(input int limit);
        int waited;
        got_q.delete();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        waited = 0;
        while (got_q.size() < exp_q.size() && waited < limit) begin
            @(negedge clk);
            waited++;
            if (out_valid) got_q.push_back(out_data);
        end
        // a quiet window catches extra outputs
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            if (out_valid) got_q.push_back(out_data);
        end
    endtask

    task automatic check_outputs();
        compare_count("out_count", got_q.size(), exp_q.size());
        for (int i = 0; i < exp_q.size(); i++) begin
            compare_word($sformatf("out_data[%0d]", i), got_q[i], exp_q[i]);
        end
    endtask

    task automatic run_program();
        run_model();
        reset_dut();
        load_program();
        run_and_collect(RUN_LIMIT);
        check_outputs();
    endtask

    task automatic alu_forwarding();
        prog_q.delete();
        put_instr(i_instr(`CPU_OP_ADDI, 1, 0, 7));
        put_instr(i_instr(`CPU_OP_ADDI, 2, 0, -3));
        put_instr(r_instr(`CPU_FN_ADD, 3, 1, 2));
        store_to_output(3);
        put_instr(r_instr(`CPU_FN_SUB, 4, 2, 3));
        store_to_output(4);
        put_instr(r_instr(`CPU_FN_AND, 5, 4, 1));
        store_to_output(5);
        put_instr(r_instr(`CPU_FN_OR, 6, 5, 2));
        store_to_output(6);
        put_instr(r_instr(`CPU_FN_SLT, 7, 2, 1));
        store_to_output(7);
        put_instr(r_instr(`CPU_FN_SLT, 8, 1, 2));
        store_to_output(8);
        end_program();
        run_program();
    endtask

    task automatic load_store_stalls();
        prog_q.delete();
        put_instr(i_instr(`CPU_OP_ADDI, 1, 0, 'h55));
        put_instr(i_instr(`CPU_OP_ADDI, 2, 0, -2));
        put_instr(i_instr(`CPU_OP_SW, 1, 0, 0));
        put_instr(i_instr(`CPU_OP_SW, 2, 0, 4));
        put_instr(i_instr(`CPU_OP_LW, 3, 0, 0));
        put_instr(r_instr(`CPU_FN_ADD, 4, 3, 0));
        store_to_output(4);
        put_instr(i_instr(`CPU_OP_LW, 5, 0, 4));
        store_to_output(5);
        put_instr(i_instr(`CPU_OP_ADDI, 6, 0, 12));
        put_instr(i_instr(`CPU_OP_SW, 1, 6, 4));
        put_instr(i_instr(`CPU_OP_LW, 7, 0, 16));
        store_to_output(7);
        end_program();
        run_program();
    endtask

    task automatic branch_loop();
        prog_q.delete();
        put_instr(i_instr(`CPU_OP_ADDI, 4, 0, 'h7ee));
        put_instr(i_instr(`CPU_OP_ADDI, 1, 0, 0));
        put_instr(i_instr(`CPU_OP_ADDI, 2, 0, 1));
        put_instr(i_instr(`CPU_OP_ADDI, 3, 0, 11));
        put_instr(r_instr(`CPU_FN_ADD, 1, 1, 2));
        put_instr(i_instr(`CPU_OP_ADDI, 2, 2, 1));
        // exit to the final store once r2 reaches 11
        put_instr(i_instr(`CPU_OP_BEQ, 3, 2, 2));
        put_instr(i_instr(`CPU_OP_BEQ, 0, 0, -4));
        store_to_output(4);
        store_to_output(1);
        end_program();
        run_program();
        compare_word("loop_sum", got_q[0], 32'd55);
    endtask

    task automatic random_program();
        logic [5:0] fn_list [5];
        word_t      r;
        int         rd;
        fn_list = '{`CPU_FN_ADD, `CPU_FN_SUB, `CPU_FN_AND, `CPU_FN_OR, `CPU_FN_SLT};
        prog_q.delete();
        for (int i = 1; i < 8; i++) begin
            r = $random(seed);
            put_instr(i_instr(`CPU_OP_ADDI, i, 0, int'(r)));
        end
        for (int n = 0; n < 20; n++) begin
            r  = $random(seed);
            rd = (r[5:3] == 3'd0) ? 1 : int'(r[5:3]);
            case (r[2:0])
                3'd5:       put_instr(i_instr(`CPU_OP_ADDI, rd, int'(r[8:6]), int'(r[31:16])));
                3'd6, 3'd7: store_to_output(int'(r[11:9]));
                default:    put_instr(r_instr(fn_list[r[2:0]], rd, int'(r[8:6]),
                                              int'(r[11:9])));
            endcase
        end
        end_program();
        run_program();
    endtask

    task automatic store_and_rerun();
        prog_q.delete();
        put_instr(i_instr(`CPU_OP_ADDI, 1, 0, 'h1234));
        put_instr(i_instr(`CPU_OP_SW, 1, 0, 8));
        put_instr(i_instr(`CPU_OP_ADDI, 0, 0, 5));
        put_instr(r_instr(`CPU_FN_ADD, 0, 1, 1));
        // r0 read right behind the r0 writes
        store_to_output(0);
        put_instr(i_instr(`CPU_OP_LW, 2, 0, 8));
        store_to_output(2);
        end_program();
        run_program();
        // second start with no reset and no reload
        run_model();
        run_and_collect(RUN_LIMIT);
        check_outputs();
    endtask

    initial begin
        arst_n    = 1'b0;
        start     = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        alu_forwarding();
        load_store_stalls();
        branch_loop();
        random_program();
        store_and_rerun();
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+hw
hw/cpu_pkg.sv
hw/fetch_stage.sv
hw/hazard_unit.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/cpu_top.sv
testbench/tb_cpu.sv

/* run.sh */
#!/bin/sh
# build the cpu testbench with Verilator, run it, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps -f project.f --top-module tb_cpu -o tb_cpu_sim \
    && ./obj_dir/tb_cpu_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "PASS: all tests" sim.log && exit 0 || exit 1
